// File: sources.f
src/irq_pkg.sv
src/irq_cfg_if.sv
src/irq_config_regs.sv
src/exti_detect.sv
src/timer_irq.sv
src/irq_arbiter.sv
src/irq_unit_top.sv
bench/tb_irq_unit.sv

// File: Makefile
TOP := tb_irq_unit

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module irq_unit_top

sim:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// File: bench/tb_irq_unit.sv
`timescale 1ns/1ps

module tb_irq_unit;
    import irq_pkg::*;

    localparam int DEBOUNCE        = 4;
    localparam int EDGE_BOUND      = 8;
    localparam int CLEAR_BOUND     = 4;
    localparam int BUS_TIMEOUT     = 16;
    localparam int ID_W            = $clog2(IRQ_SRC_N);
    // Largest random limit 15 and prescaler 3
    localparam int TIMER_BOUND_MAX = 16 * 8 + 4;
    localparam int WATCHDOG_CYCLES = 200 + 300 + 200 + (3 * TIMER_BOUND_MAX + 200) + 400 + 1000;

    localparam logic [ID_W-1:0]      ID_EXTI    = ID_W'(IRQ_EXTI);
    localparam logic [ID_W-1:0]      ID_TIMER   = ID_W'(IRQ_TIMER);
    localparam logic [WB_DATA_W-1:0] STAT_EXTI  = WB_DATA_W'(1 << IRQ_EXTI);
    localparam logic [WB_DATA_W-1:0] STAT_TIMER = WB_DATA_W'(1 << IRQ_TIMER);

    logic                 clk;
    logic                 rst_n;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [WB_ADDR_W-1:0] wb_adr;
    logic [WB_DATA_W-1:0] wb_dat_w;
    logic [WB_DATA_W-1:0] wb_dat_r;
    logic                 wb_ack;
    logic                 exti_pin;
    logic                 irq;
    logic [ID_W-1:0]      irq_id;

    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    logic [31:0] lcg_state;

    irq_unit_top #(
        .DEBOUNCE_CYCLES (DEBOUNCE)
    ) DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .exti_pin (exti_pin),
        .irq      (irq),
        .irq_id   (irq_id)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run aborted", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [WB_DATA_W-1:0] exti_cfg_byte(input logic en,
                                                          input logic [EXTI_SENSE_W-1:0] sense,
                                                          input logic debounce);
        logic [WB_DATA_W-1:0] b;
        b = '0;
        b[EXTI_EN_BIT] = en;
        b[EXTI_SENSE_LSB +: EXTI_SENSE_W] = sense;
        b[EXTI_DEBOUNCE_BIT] = debounce;
        return b;
    endfunction

    function automatic logic [WB_DATA_W-1:0] timer_cfg_byte(input logic en, input logic mode,
                                                           input logic [TMR_PRESCALE_W-1:0] pre);
        logic [WB_DATA_W-1:0] b;
        b = '0;
        b[TMR_EN_BIT] = en;
        b[TMR_MODE_BIT] = mode;
        b[TMR_PRESCALE_W-1:0] = pre;
        return b;
    endfunction

    task automatic report_failure(input string msg);
        errors++;
        $display("Failure: %s", msg);
    endtask

    task automatic check_byte(input string name, input logic [WB_DATA_W-1:0] actual,
                              input logic [WB_DATA_W-1:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, actual, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic check_id(input string name, input logic [ID_W-1:0] actual,
                            input logic [ID_W-1:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // One classic cycle held until ack
    task automatic bus_cycle(input logic we, input logic [WB_ADDR_W-1:0] adr,
                             input logic [WB_DATA_W-1:0] wdata,
                             output logic [WB_DATA_W-1:0] rdata);
        int waits;
        waits = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        @(negedge clk);
        while (!wb_ack && waits < BUS_TIMEOUT) begin
            waits++;
            @(negedge clk);
        end
        rdata = wb_dat_r;
        checks++;
        if (!wb_ack) begin
            report_failure($sformatf("no wb_ack within %0d cycles at address %0d",
                                     BUS_TIMEOUT, adr));
        end else if (waits != 1) begin
            report_failure($sformatf("wb_ack came %0d cycles after the request instead of 1",
                                     waits));
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        check_bit("wb_ack", wb_ack, 1'b0);
    endtask

    task automatic wb_write(input logic [WB_ADDR_W-1:0] adr, input logic [WB_DATA_W-1:0] data);
        logic [WB_DATA_W-1:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [WB_ADDR_W-1:0] adr, output logic [WB_DATA_W-1:0] data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    task automatic read_and_check(input logic [WB_ADDR_W-1:0] adr,
                                  input logic [WB_DATA_W-1:0] expected, input string name);
        logic [WB_DATA_W-1:0] rd;
        wb_read(adr, rd);
        check_byte(name, rd, expected);
    endtask

    task automatic set_pin(input logic level);
        @(posedge clk);
        exti_pin <= level;
    endtask

    task automatic wait_for_irq(input logic level, input int bound, input string what);
        int n;
        n = 0;
        checks++;
        @(negedge clk);
        while (irq !== level && n < bound) begin
            n++;
            @(negedge clk);
        end
        if (irq !== level) begin
            report_failure($sformatf("irq did not go to %0d within %0d cycles (%s)",
                                     level, bound, what));
        end
    endtask

    task automatic wait_for_id(input logic [ID_W-1:0] id, input int bound, input string what);
        int n;
        n = 0;
        checks++;
        @(negedge clk);
        while (!(irq === 1'b1 && irq_id === id) && n < bound) begin
            n++;
            @(negedge clk);
        end
        if (!(irq === 1'b1 && irq_id === id)) begin
            report_failure($sformatf("irq with id %0d not seen within %0d cycles (%s)",
                                     id, bound, what));
        end
    endtask

    task automatic expect_no_irq(input int cycles, input string what);
        bit seen;
        seen = 1'b0;
        checks++;
        repeat (cycles) begin
            @(negedge clk);
            if (irq !== 1'b0) begin
                seen = 1'b1;
            end
        end
        if (seen) begin
            report_failure($sformatf("irq was raised unexpectedly (%s)", what));
        end
    endtask

    task automatic clear_pending(input logic [WB_DATA_W-1:0] mask);
        wb_write(REG_IRQ_STATUS, mask);
    endtask

    task automatic edge_sets_irq(input logic level, input string what);
        set_pin(level);
        wait_for_irq(1'b1, EDGE_BOUND, what);
        check_id("irq_id", irq_id, ID_EXTI);
        read_and_check(REG_IRQ_STATUS, STAT_EXTI, "irq_status");
        clear_pending(STAT_EXTI);
        wait_for_irq(1'b0, CLEAR_BOUND, {what, ", clear"});
    endtask

    task automatic edge_is_ignored(input logic level, input string what);
        set_pin(level);
        expect_no_irq(EDGE_BOUND, what);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAILED with %0d errors", name, errors - errors_before);
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////
    task automatic test_register_access();
        int                   e0;
        logic [31:0]          rnd;
        logic [WB_DATA_W-1:0] data [4];
        e0 = errors;
        // Defaults below also show that unmapped writes are ignored
        for (int a = 5; a < 8; a++) begin
            wb_write(3'(a), 8'h5a);
        end
        read_and_check(REG_EXTI_CFG, 8'h00, "exti_cfg");
        read_and_check(REG_TIMER_CFG, 8'h00, "timer_cfg");
        read_and_check(REG_TIMER_LIM_L, TIMER_LIMIT_DEFAULT[7:0], "timer_lim_l");
        read_and_check(REG_TIMER_LIM_H, TIMER_LIMIT_DEFAULT[15:8], "timer_lim_h");
        read_and_check(REG_IRQ_STATUS, 8'h00, "irq_status");
        for (int a = 5; a < 8; a++) begin
            read_and_check(3'(a), 8'h00, "unmapped");
        end
        for (int a = 0; a < 4; a++) begin
            rnd = next_random();
            data[a] = rnd[23:16];
            wb_write(3'(a), data[a]);
        end
        for (int a = 0; a < 4; a++) begin
            read_and_check(3'(a), data[a], $sformatf("reg %0d readback", a));
        end
        // Random config may have started a source
        wb_write(REG_EXTI_CFG, 8'h00);
        wb_write(REG_TIMER_CFG, 8'h00);
        wb_write(REG_TIMER_LIM_L, 8'hff);
        wb_write(REG_TIMER_LIM_H, 8'hff);
        clear_pending(STAT_EXTI | STAT_TIMER);
        wait_for_irq(1'b0, CLEAR_BOUND, "cleanup");
        read_and_check(REG_IRQ_STATUS, 8'h00, "irq_status");
        finish_test("register access", e0);
    endtask

    task automatic test_exti_edges();
        int e0;
        e0 = errors;
        set_pin(1'b0);
        wait_cycles(6);
        wb_write(REG_EXTI_CFG, exti_cfg_byte(1'b1, SENSE_RISING, 1'b0));
        edge_sets_irq(1'b1, "rising sense, rising edge");
        edge_is_ignored(1'b0, "rising sense, falling edge");
        wb_write(REG_EXTI_CFG, exti_cfg_byte(1'b1, SENSE_FALLING, 1'b0));
        edge_is_ignored(1'b1, "falling sense, rising edge");
        edge_sets_irq(1'b0, "falling sense, falling edge");
        wb_write(REG_EXTI_CFG, exti_cfg_byte(1'b1, SENSE_CHANGE, 1'b0));
        edge_sets_irq(1'b1, "change sense, rising edge");
        edge_sets_irq(1'b0, "change sense, falling edge");
        wb_write(REG_EXTI_CFG, 8'h00);
        finish_test("exti edges", e0);
    endtask

    task automatic test_debounce();
        int e0;
        e0 = errors;
        set_pin(1'b0);
        wait_cycles(6);
        wb_write(REG_EXTI_CFG, exti_cfg_byte(1'b1, SENSE_RISING, 1'b1));
        // Glitch one cycle short of the debounce time
        set_pin(1'b1);
        wait_cycles(DEBOUNCE - 2);
        set_pin(1'b0);
        expect_no_irq(DEBOUNCE + EDGE_BOUND, "short pulse with debounce");
        set_pin(1'b1);
        wait_for_irq(1'b1, DEBOUNCE + EDGE_BOUND, "held level with debounce");
        check_id("irq_id", irq_id, ID_EXTI);
        clear_pending(STAT_EXTI);
        wait_for_irq(1'b0, CLEAR_BOUND, "debounce clear");
        wb_write(REG_EXTI_CFG, 8'h00);
        set_pin(1'b0);
        wait_cycles(6);
        finish_test("debounce", e0);
    endtask

    task automatic test_timer_limit();
        int                        e0;
        int                        bound;
        logic [31:0]               rnd;
        logic [TIMER_W-1:0]        limit;
        logic [TMR_PRESCALE_W-1:0] pre;
        e0 = errors;
        rnd = next_random();
        limit = {12'h000, rnd[19:16]};
        pre = {1'b0, rnd[25:24]};
        bound = ((int'(limit) + 1) << pre) + 4;
        wb_write(REG_TIMER_LIM_L, limit[7:0]);
        wb_write(REG_TIMER_LIM_H, limit[15:8]);
        wb_write(REG_TIMER_CFG, timer_cfg_byte(1'b1, 1'b1, pre));
        wait_for_irq(1'b1, bound, "first timer request");
        check_id("irq_id", irq_id, ID_TIMER);
        read_and_check(REG_IRQ_STATUS, STAT_TIMER, "irq_status");
        // Stop, clear, restart
        wb_write(REG_TIMER_CFG, timer_cfg_byte(1'b0, 1'b1, pre));
        clear_pending(STAT_TIMER);
        wait_for_irq(1'b0, CLEAR_BOUND, "timer clear");
        wb_write(REG_TIMER_CFG, timer_cfg_byte(1'b1, 1'b1, pre));
        wait_for_irq(1'b1, bound, "timer request after clear");
        check_id("irq_id", irq_id, ID_TIMER);
        wb_write(REG_TIMER_CFG, timer_cfg_byte(1'b0, 1'b1, pre));
        clear_pending(STAT_TIMER);
        wait_for_irq(1'b0, CLEAR_BOUND, "timer clear");
        expect_no_irq(bound, "timer disabled");
        finish_test($sformatf("timer limit %0d prescale %0d", limit, pre), e0);
    endtask

    task automatic test_priority();
        int e0;
        e0 = errors;
        set_pin(1'b0);
        wait_cycles(6);
        wb_write(REG_EXTI_CFG, exti_cfg_byte(1'b1, SENSE_RISING, 1'b0));
        wb_write(REG_TIMER_LIM_L, 8'd3);
        wb_write(REG_TIMER_LIM_H, 8'd0);
        wb_write(REG_TIMER_CFG, timer_cfg_byte(1'b1, 1'b1, 3'd0));
        wait_for_irq(1'b1, 4 + 4, "timer request");
        check_id("irq_id", irq_id, ID_TIMER);
        wb_write(REG_TIMER_CFG, timer_cfg_byte(1'b0, 1'b1, 3'd0));
        set_pin(1'b1);
        wait_for_id(ID_EXTI, EDGE_BOUND, "external over timer");
        read_and_check(REG_IRQ_STATUS, STAT_EXTI | STAT_TIMER, "irq_status");
        check_id("irq_id", irq_id, ID_EXTI);
        clear_pending(STAT_EXTI);
        wait_for_id(ID_TIMER, CLEAR_BOUND, "after external clear");
        clear_pending(STAT_TIMER);
        wait_for_irq(1'b0, CLEAR_BOUND, "after timer clear");
        read_and_check(REG_IRQ_STATUS, 8'h00, "irq_status");
        wb_write(REG_EXTI_CFG, 8'h00);
        set_pin(1'b0);
        finish_test("priority and clearing", e0);
    endtask

    initial begin
        lcg_state    = 32'h90758e2e;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        exti_pin     = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        wait_cycles(2);
        test_register_access();
        test_exti_edges();
        test_debounce();
        test_timer_limit();
        test_priority();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: src/irq_unit_top.sv
`timescale 1ns/1ps

module irq_unit_top #(
    parameter int DEBOUNCE_CYCLES = 4
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    // Wishbone slave
    input  logic                                   wb_cyc,
    input  logic                                   wb_stb,
    input  logic                                   wb_we,
    input  logic [irq_pkg::WB_ADDR_W-1:0]          wb_adr,
    input  logic [irq_pkg::WB_DATA_W-1:0]          wb_dat_w,
    output logic [irq_pkg::WB_DATA_W-1:0]          wb_dat_r,
    output logic                                   wb_ack,
    // External interrupt pin
    input  logic                                   exti_pin,
    // Interrupt outputs
    output logic                                   irq,
    output logic [$clog2(irq_pkg::IRQ_SRC_N)-1:0]  irq_id
);

    logic exti_req;
    logic tmr_req;

    irq_cfg_if cfg_if ();

    //////////////////////////////////////////////////
    // Configuration and status registers
    //////////////////////////////////////////////////
    irq_config_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .cfg      (cfg_if.regs)
    );

    // Interrupt sources
    exti_detect #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_exti (
        .clk   (clk),
        .rst_n (rst_n),
        .pin   (exti_pin),
        .cfg   (cfg_if.exti),
        .req   (exti_req)
    );

    timer_irq u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .cfg   (cfg_if.timer),
        .req   (tmr_req)
    );

    // Merge into one pending view
    irq_arbiter u_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .exti_req (exti_req),
        .tmr_req  (tmr_req),
        .cfg      (cfg_if.arbiter),
        .irq      (irq),
        .irq_id   (irq_id)
    );

endmodule

// File: src/irq_arbiter.sv
`timescale 1ns/1ps

module irq_arbiter (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   exti_req,
    input  logic                                   tmr_req,
    irq_cfg_if.arbiter                             cfg,
    output logic                                   irq,
    output logic [$clog2(irq_pkg::IRQ_SRC_N)-1:0]  irq_id
);
    import irq_pkg::*;

    localparam int ID_W = $clog2(IRQ_SRC_N);

    logic [IRQ_SRC_N-1:0] req_vec;
    logic [IRQ_SRC_N-1:0] pending_q;

    // Request lines placed by source number
    always_comb begin
        req_vec            = '0;
        req_vec[IRQ_EXTI]  = exti_req;
        req_vec[IRQ_TIMER] = tmr_req;
    end

    //////////////////////////////////////////////////
    // Pending latches
    //////////////////////////////////////////////////

    // Request beats a clear of the same bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~cfg.clear_mask) | req_vec;
        end
    end

    assign cfg.pending = pending_q;
    assign irq         = |pending_q;

    // Lowest source number wins, so external goes first
    always_comb begin
        irq_id = '0;
        for (int i = IRQ_SRC_N - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                irq_id = ID_W'(i);
            end
        end
    end

endmodule

// File: src/timer_irq.sv
`timescale 1ns/1ps

module timer_irq (
    input  logic      clk,
    input  logic      rst_n,
    irq_cfg_if.timer  cfg,
    output logic      req
);
    import irq_pkg::*;

    // Enough prescaler bits for the largest division
    localparam int PRE_W = (1 << TMR_PRESCALE_W) - 1;

    logic [PRE_W-1:0]   pre_q;
    logic [PRE_W-1:0]   pre_mask;
    logic               tick;
    logic [TIMER_W-1:0] cnt_q;
    logic [TIMER_W-1:0] wrap_at;
    logic               hit;
    logic               req_q;

    //////////////////////////////////////////////////
    // Prescaler
    //////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < PRE_W; i++) begin
            pre_mask[i] = (i < cfg.tmr_prescale);
        end
    end

    // Tick once every 2^prescale clocks
    assign tick = ((pre_q & pre_mask) == pre_mask);

    always_ff @(posedge clk) begin
        if (!rst_n || !cfg.tmr_en) begin
            pre_q <= '0;
        end else begin
            pre_q <= pre_q + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Counter
    //////////////////////////////////////////////////

    // Limit mode wraps at the limit word, overflow mode at all ones
    assign wrap_at = cfg.tmr_mode ? cfg.tmr_limit.word : '1;

    // Also catches a count left above a freshly lowered limit
    assign hit = (cnt_q >= wrap_at);

    always_ff @(posedge clk) begin
        if (!rst_n || !cfg.tmr_en) begin
            cnt_q <= '0;
            req_q <= 1'b0;
        end else begin
            req_q <= tick && hit;
            if (tick) begin
                if (hit) begin
                    cnt_q <= '0;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    assign req = req_q;

endmodule

// File: src/exti_detect.sv
`timescale 1ns/1ps

module exti_detect #(
    parameter int DEBOUNCE_CYCLES = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     pin,
    irq_cfg_if.exti  cfg,
    output logic     req
);
    import irq_pkg::*;

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEBOUNCE_CYCLES);

    logic [1:0]       sync_q;
    logic [CNT_W-1:0] db_cnt_q;
    logic             level_q;
    logic             level_d;
    logic             rise;
    logic             fall;
    logic             hit;
    logic             req_q;

    // Two-flop synchronizer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[0], pin};
        end
    end

    //////////////////////////////////////////////////
    // Debounce
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            db_cnt_q <= '0;
        end else if (!cfg.exti_debounce || (sync_q[1] == level_q)) begin
            db_cnt_q <= '0;
        end else if (db_cnt_q != CNT_MAX) begin
            db_cnt_q <= db_cnt_q + 1'b1;
        end
    end

    // New level is taken once it has held long enough
    assign level_d = !cfg.exti_debounce  ? sync_q[1] :
                     (db_cnt_q == CNT_MAX) ? sync_q[1] : level_q;

    assign rise = level_d && !level_q;
    assign fall = !level_d && level_q;

    always_comb begin
        case (cfg.exti_sense)
            SENSE_RISING:  hit = rise;
            SENSE_FALLING: hit = fall;
            SENSE_CHANGE:  hit = rise || fall;
            // Unused code, treated as change
            default:       hit = rise || fall;
        endcase
    end

    // Edge register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            level_q <= 1'b0;
            req_q   <= 1'b0;
        end else begin
            level_q <= level_d;
            req_q   <= hit && cfg.exti_en;
        end
    end

    assign req = req_q;

endmodule

// File: src/irq_config_regs.sv
`timescale 1ns/1ps

module irq_config_regs (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  logic [irq_pkg::WB_ADDR_W-1:0]  wb_adr,
    input  logic [irq_pkg::WB_DATA_W-1:0]  wb_dat_w,
    output logic [irq_pkg::WB_DATA_W-1:0]  wb_dat_r,
    output logic                           wb_ack,
    irq_cfg_if.regs                        cfg
);
    import irq_pkg::*;

    logic                  ack_q;
    logic                  bus_req;
    logic                  bus_wr;
    logic [WB_DATA_W-1:0]  exti_cfg_q;
    logic [WB_DATA_W-1:0]  tmr_cfg_q;
    timer_limit_u          limit_q;
    logic [IRQ_SRC_N-1:0]  clear_q;
    logic [WB_DATA_W-1:0]  rd_mux;
    logic [WB_DATA_W-1:0]  dat_r_q;

    // New request only, so ack drops for a cycle between transfers
    assign bus_req = wb_cyc && wb_stb && !ack_q;
    assign bus_wr  = bus_req && wb_we;

    //////////////////////////////////////////////////
    // Register writes
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q         <= 1'b0;
            clear_q       <= '0;
            exti_cfg_q    <= '0;
            tmr_cfg_q     <= '0;
            limit_q.word  <= TIMER_LIMIT_DEFAULT;
        end else begin
            ack_q   <= bus_req;
            // Clear strobe lasts one cycle
            clear_q <= '0;
            if (bus_wr) begin
                case (wb_adr)
                    REG_EXTI_CFG:    exti_cfg_q       <= wb_dat_w;
                    REG_TIMER_CFG:   tmr_cfg_q        <= wb_dat_w;
                    REG_TIMER_LIM_L: limit_q.bytes[0] <= wb_dat_w;
                    REG_TIMER_LIM_H: limit_q.bytes[1] <= wb_dat_w;
                    REG_IRQ_STATUS:  clear_q          <= wb_dat_w[IRQ_SRC_N-1:0];
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////
    always_comb begin
        case (wb_adr)
            REG_EXTI_CFG:    rd_mux = exti_cfg_q;
            REG_TIMER_CFG:   rd_mux = tmr_cfg_q;
            REG_TIMER_LIM_L: rd_mux = limit_q.bytes[0];
            REG_TIMER_LIM_H: rd_mux = limit_q.bytes[1];
            REG_IRQ_STATUS:  rd_mux = {{(WB_DATA_W - IRQ_SRC_N){1'b0}}, cfg.pending};
            default:         rd_mux = '0;
        endcase
    end

    // Captured with the request, valid while ack is high
    always_ff @(posedge clk) begin
        if (bus_req) begin
            dat_r_q <= rd_mux;
        end
    end

    assign wb_ack   = ack_q;
    assign wb_dat_r = dat_r_q;

    // Field decode toward the sources
    assign cfg.exti_en       = exti_cfg_q[EXTI_EN_BIT];
    assign cfg.exti_sense    = exti_cfg_q[EXTI_SENSE_LSB +: EXTI_SENSE_W];
    assign cfg.exti_debounce = exti_cfg_q[EXTI_DEBOUNCE_BIT];
    assign cfg.tmr_en        = tmr_cfg_q[TMR_EN_BIT];
    assign cfg.tmr_mode      = tmr_cfg_q[TMR_MODE_BIT];
    assign cfg.tmr_prescale  = tmr_cfg_q[TMR_PRESCALE_W-1:0];
    assign cfg.tmr_limit     = limit_q;
    assign cfg.clear_mask    = clear_q;

endmodule

// File: src/irq_cfg_if.sv
`timescale 1ns/1ps

interface irq_cfg_if;
    import irq_pkg::*;

    // External pin setup
    logic                      exti_en;
    logic [EXTI_SENSE_W-1:0]   exti_sense;
    logic                      exti_debounce;

    // Timer setup
    logic                      tmr_en;
    logic                      tmr_mode;
    logic [TMR_PRESCALE_W-1:0] tmr_prescale;
    timer_limit_u              tmr_limit;

    // Status path
    logic [IRQ_SRC_N-1:0]      clear_mask;
    logic [IRQ_SRC_N-1:0]      pending;

    modport regs (
        output exti_en, exti_sense, exti_debounce,
        output tmr_en, tmr_mode, tmr_prescale, tmr_limit,
        output clear_mask,
        input  pending
    );

    modport exti (input exti_en, exti_sense, exti_debounce);

    modport timer (input tmr_en, tmr_mode, tmr_prescale, tmr_limit);

    modport arbiter (
        input  clear_mask,
        output pending
    );

endinterface

// File: src/irq_pkg.sv
package irq_pkg;

    //////////////////////////////////////////////////
    // Bus geometry
    //////////////////////////////////////////////////
    localparam int WB_ADDR_W = 3;
    localparam int WB_DATA_W = 8;

    // Register map
    localparam logic [WB_ADDR_W-1:0] REG_EXTI_CFG    = 3'd0;
    localparam logic [WB_ADDR_W-1:0] REG_TIMER_CFG   = 3'd1;
    localparam logic [WB_ADDR_W-1:0] REG_TIMER_LIM_L = 3'd2;
    localparam logic [WB_ADDR_W-1:0] REG_TIMER_LIM_H = 3'd3;
    localparam logic [WB_ADDR_W-1:0] REG_IRQ_STATUS  = 3'd4;

    //////////////////////////////////////////////////
    // External interrupt config byte
    //////////////////////////////////////////////////
    localparam int EXTI_EN_BIT       = 7;
    localparam int EXTI_SENSE_LSB    = 5;
    localparam int EXTI_SENSE_W      = 2;
    localparam int EXTI_DEBOUNCE_BIT = 4;

    // Sense codes, code 3 acts as change
    localparam logic [EXTI_SENSE_W-1:0] SENSE_RISING  = 2'd0;
    localparam logic [EXTI_SENSE_W-1:0] SENSE_FALLING = 2'd1;
    localparam logic [EXTI_SENSE_W-1:0] SENSE_CHANGE  = 2'd2;

    //////////////////////////////////////////////////
    // Timer config byte
    //////////////////////////////////////////////////
    localparam int TMR_EN_BIT     = 7;
    localparam int TMR_MODE_BIT   = 6;
    localparam int TMR_PRESCALE_W = 3;
    localparam int TIMER_W        = 16;

    // Interrupt sources, bit positions in pending and clear masks
    localparam int IRQ_SRC_N = 2;
    localparam int IRQ_EXTI  = 0;
    localparam int IRQ_TIMER = 1;

    localparam logic [TIMER_W-1:0] TIMER_LIMIT_DEFAULT = '1;

    // Limit word, seen whole by the timer and bytewise by the bus
    typedef union packed {
        logic [TIMER_W-1:0]                          word;
        logic [TIMER_W/WB_DATA_W-1:0][WB_DATA_W-1:0] bytes;
    } timer_limit_u;

endpackage
